//--- run_sim.sh
#!/bin/sh
# Build the data cache testbench with Verilator and run it.
# The exit status is the simulator's own.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_data_cache -f tb.f -o sim_data_cache
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status."
    exit "$status"
fi

./obj_dir/sim_data_cache
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status."
    exit "$status"
fi

echo "Simulation finished."
exit 0

//--- source/burst_counter.sv
// --------------------
// Beat index for refill and write-back bursts.
// --------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module burst_counter (
    input  logic                      clk,
    input  logic                      arst,
    input  logic                      i_clear,
    input  logic                      i_step,
    output logic [`CACHE_WORD_W-1:0]  o_beat,
    output logic                      o_last
);

    // Wraps to 0 after the last beat.
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            o_beat <= '0;
        end else if (i_clear) begin
            o_beat <= '0;
        end else if (i_step) begin
            o_beat <= o_beat + 1'b1;
        end
    end

    assign o_last = (o_beat == '1);

    a_no_step_on_clear: assert property (@(posedge clk) disable iff (arst)
        !(i_step && i_clear))
        else $error("Counter stepped and cleared in one cycle.");

endmodule

//--- source/cache_consts.svh
// --------------------
// Cache geometry and bus width macros.
// Address layout: tag [31:8], set [7:4], word [3:2], byte [1:0].
// --------------------
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Bus widths.
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32

// Geometry.
`define CACHE_WAYS  4
`define CACHE_SETS  16
`define CACHE_WORDS 4

// Index and tag widths.
`define CACHE_WAY_W  2
`define CACHE_SET_W  4
`define CACHE_WORD_W 2
`define CACHE_TAG_W  24

`endif

//--- source/cache_data_array.sv
// --------------------
// Line storage, 16 sets x 4 ways x 4 words.
// Asynchronous word read, synchronous word write.
// --------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module cache_data_array (
    input  logic                       clk,
    input  cache_types_pkg::set_idx_t  i_set,
    input  cache_types_pkg::way_idx_t  i_way,
    input  cache_types_pkg::word_idx_t i_word,
    input  logic                       i_we,
    input  logic [`CACHE_DATA_W-1:0]   i_wdata,
    output logic [`CACHE_DATA_W-1:0]   o_rdata
);

    logic [`CACHE_DATA_W-1:0] mem_q [`CACHE_SETS][`CACHE_WAYS][`CACHE_WORDS];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem_q[i_set][i_way][i_word] <= i_wdata;
        end
    end

    assign o_rdata = mem_q[i_set][i_way][i_word];

endmodule

//--- source/cache_tag_array.sv
// --------------------
// Tag, valid and dirty storage.
// Parallel hit detection and victim line status.
// --------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module cache_tag_array (
    input  logic                          clk,
    input  logic                          arst,
    input  cache_types_pkg::cache_addr_t  i_addr,
    input  cache_types_pkg::way_idx_t     i_victim_way,
    input  logic                          i_tag_write,
    input  logic                          i_dirty_set,
    output logic                          o_hit,
    output cache_types_pkg::way_idx_t     o_hit_way,
    output logic                          o_victim_dirty,
    output cache_types_pkg::tag_t         o_victim_tag
);
    import cache_types_pkg::*;

    tag_t                   tag_q   [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0] match;

    // --------------------
    // Lookup.
    // --------------------
    always_comb begin
        o_hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            match[w] = valid_q[i_addr.set][w] && (tag_q[i_addr.set][w] == i_addr.tag);
            if (match[w]) begin
                o_hit_way = way_idx_t'(w);
            end
        end
    end

    assign o_hit          = |match;
    assign o_victim_tag   = tag_q[i_addr.set][i_victim_way];
    assign o_victim_dirty = valid_q[i_addr.set][i_victim_way]
                          & dirty_q[i_addr.set][i_victim_way];

    // --------------------
    // Update.
    // --------------------
    always_ff @(posedge clk) begin
        if (i_tag_write) begin
            tag_q[i_addr.set][i_victim_way] <= i_addr.tag;
        end
    end

    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (i_tag_write) begin
            // New line comes in clean.
            valid_q[i_addr.set][i_victim_way] <= 1'b1;
            dirty_q[i_addr.set][i_victim_way] <= 1'b0;
        end else if (i_dirty_set) begin
            dirty_q[i_addr.set][o_hit_way] <= 1'b1;
        end
    end

    a_single_match: assert property (@(posedge clk) disable iff (arst)
        $onehot0(match))
        else $error("Same tag present in two ways of a set.");

endmodule

//--- source/cache_types_pkg.sv
// --------------------
// CPU request and response structs, CPU opcode,
// controller states and address field types.
// --------------------
`include "cache_consts.svh"

package cache_types_pkg;

    // Address fields.
    typedef logic [`CACHE_TAG_W-1:0]  tag_t;
    typedef logic [`CACHE_SET_W-1:0]  set_idx_t;
    typedef logic [`CACHE_WORD_W-1:0] word_idx_t;
    typedef logic [`CACHE_WAY_W-1:0]  way_idx_t;

    typedef struct packed {
        tag_t      tag;
        set_idx_t  set;
        word_idx_t word;
        logic [1:0] byte_off;
    } cache_addr_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cpu_op_e;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_COMPARE   = 3'd1,
        ST_WB_ADDR   = 3'd2,
        ST_WB_DATA   = 3'd3,
        ST_WB_RESP   = 3'd4,
        ST_FILL_ADDR = 3'd5,
        ST_FILL_DATA = 3'd6
    } cache_state_e;

    // CPU port.
    typedef struct packed {
        logic                     valid;
        cpu_op_e                  op;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                     done;
        logic [`CACHE_DATA_W-1:0] rdata;
    } cpu_rsp_t;

endpackage

//--- source/data_cache_fsm.sv
// --------------------
// Cache controller FSM.
// Request register, compare, write-back and refill
// sequencing, memory handshake control.
// --------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module data_cache_fsm (
    input  logic                        clk,
    input  logic                        arst,
    input  cache_types_pkg::cpu_req_t   i_req,
    input  logic                        i_hit,
    input  logic                        i_victim_dirty,
    input  logic                        i_beat_last,
    input  mem_bus_pkg::mem_rd_rsp_t    i_rd_rsp,
    input  mem_bus_pkg::mem_wr_rsp_t    i_wr_rsp,
    output cache_types_pkg::cache_addr_t o_addr,
    output cache_types_pkg::cpu_op_e    o_op,
    output logic [`CACHE_DATA_W-1:0]    o_wdata,
    output logic                        o_done,
    output logic                        o_tag_write,
    output logic                        o_dirty_set,
    output logic                        o_lru_touch,
    output logic                        o_data_we,
    output logic                        o_data_src_fill,
    output logic                        o_use_victim,
    output logic                        o_cnt_clear,
    output logic                        o_cnt_step,
    output mem_bus_pkg::mem_rd_req_t    o_rd_req,
    output mem_bus_pkg::mem_wr_req_t    o_wr_ctl
);
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    cache_state_e state;
    cache_state_e state_nxt;

    // --------------------
    // Request register.
    // --------------------
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_req.valid) begin
            o_addr  <= cache_addr_t'(i_req.addr);
            o_op    <= i_req.op;
            o_wdata <= i_req.wdata;
        end
    end

    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Data array follows the victim way everywhere but compare.
    assign o_use_victim = (state != ST_COMPARE);

    // --------------------
    // Next state and outputs.
    // --------------------
    always_comb begin
        state_nxt       = state;
        o_done          = 1'b0;
        o_tag_write     = 1'b0;
        o_dirty_set     = 1'b0;
        o_lru_touch     = 1'b0;
        o_data_we       = 1'b0;
        o_data_src_fill = 1'b0;
        o_cnt_clear     = 1'b0;
        o_cnt_step      = 1'b0;
        o_rd_req        = '0;
        o_wr_ctl        = '0;
        // Refill always targets the aligned line of the request.
        o_rd_req.araddr = {o_addr.tag, o_addr.set, {(`CACHE_WORD_W + 2){1'b0}}};

        case (state)
            ST_IDLE: begin
                if (i_req.valid) begin
                    state_nxt = ST_COMPARE;
                end
            end

            ST_COMPARE: begin
                if (i_hit) begin
                    o_done      = 1'b1;
                    o_lru_touch = 1'b1;
                    if (o_op == OP_WRITE) begin
                        o_data_we   = 1'b1;
                        o_dirty_set = 1'b1;
                    end
                    state_nxt = ST_IDLE;
                end else begin
                    o_cnt_clear = 1'b1;
                    state_nxt   = i_victim_dirty ? ST_WB_ADDR : ST_FILL_ADDR;
                end
            end

            ST_WB_ADDR: begin
                o_wr_ctl.awvalid = 1'b1;
                if (i_wr_rsp.awready) begin
                    state_nxt = ST_WB_DATA;
                end
            end

            ST_WB_DATA: begin
                o_wr_ctl.wvalid = 1'b1;
                o_wr_ctl.wlast  = i_beat_last;
                if (i_wr_rsp.wready) begin
                    o_cnt_step = 1'b1;
                    if (i_beat_last) begin
                        state_nxt = ST_WB_RESP;
                    end
                end
            end

            // Beat index has wrapped back to 0 for the refill.
            ST_WB_RESP: begin
                if (i_wr_rsp.bvalid) begin
                    state_nxt = ST_FILL_ADDR;
                end
            end

            ST_FILL_ADDR: begin
                o_rd_req.arvalid = 1'b1;
                if (i_rd_rsp.arready) begin
                    state_nxt = ST_FILL_DATA;
                end
            end

            ST_FILL_DATA: begin
                if (i_rd_rsp.rvalid) begin
                    o_data_we       = 1'b1;
                    o_data_src_fill = 1'b1;
                    o_cnt_step      = 1'b1;
                    if (i_rd_rsp.rlast) begin
                        o_tag_write = 1'b1;
                        state_nxt   = ST_COMPARE;
                    end
                end
            end

            default: state_nxt = ST_IDLE;
        endcase
    end

    // --------------------
    // Checks.
    // --------------------
    a_rlast_on_last_beat: assert property (@(posedge clk) disable iff (arst)
        (i_rd_rsp.rvalid && i_rd_rsp.rlast) |-> i_beat_last)
        else $error("rlast out of step with the beat counter.");

    a_one_addr_channel: assert property (@(posedge clk) disable iff (arst)
        !(o_rd_req.arvalid && o_wr_ctl.awvalid))
        else $error("arvalid and awvalid high together.");

endmodule

//--- source/data_cache_top.sv
// --------------------
// Data cache top level.
// Controller, beat counter, tag, LRU and data arrays.
// --------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module data_cache_top (
    input  logic                      clk,
    input  logic                      arst,
    input  cache_types_pkg::cpu_req_t i_cpu_req,
    input  mem_bus_pkg::mem_rd_rsp_t  i_mem_rd_rsp,
    input  mem_bus_pkg::mem_wr_rsp_t  i_mem_wr_rsp,
    output cache_types_pkg::cpu_rsp_t o_cpu_rsp,
    output mem_bus_pkg::mem_rd_req_t  o_mem_rd_req,
    output mem_bus_pkg::mem_wr_req_t  o_mem_wr_req
);
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    cache_addr_t              addr;
    cpu_op_e                  op;
    logic [`CACHE_DATA_W-1:0] wdata;
    logic                     done;
    logic                     tag_write;
    logic                     dirty_set;
    logic                     lru_touch;
    logic                     data_we;
    logic                     data_src_fill;
    logic                     use_victim;
    logic                     cnt_clear;
    logic                     cnt_step;
    logic                     hit;
    logic                     victim_dirty;
    way_idx_t                 hit_way;
    way_idx_t                 victim_way;
    tag_t                     victim_tag;
    word_idx_t                beat;
    logic                     beat_last;
    mem_wr_req_t              wr_ctl;
    logic [`CACHE_DATA_W-1:0] data_rdata;
    logic [`CACHE_DATA_W-1:0] data_wdata;

    data_cache_fsm u_fsm (
        .clk             (clk),
        .arst            (arst),
        .i_req           (i_cpu_req),
        .i_hit           (hit),
        .i_victim_dirty  (victim_dirty),
        .i_beat_last     (beat_last),
        .i_rd_rsp        (i_mem_rd_rsp),
        .i_wr_rsp        (i_mem_wr_rsp),
        .o_addr          (addr),
        .o_op            (op),
        .o_wdata         (wdata),
        .o_done          (done),
        .o_tag_write     (tag_write),
        .o_dirty_set     (dirty_set),
        .o_lru_touch     (lru_touch),
        .o_data_we       (data_we),
        .o_data_src_fill (data_src_fill),
        .o_use_victim    (use_victim),
        .o_cnt_clear     (cnt_clear),
        .o_cnt_step      (cnt_step),
        .o_rd_req        (o_mem_rd_req),
        .o_wr_ctl        (wr_ctl)
    );

    burst_counter u_cnt (
        .clk     (clk),
        .arst    (arst),
        .i_clear (cnt_clear),
        .i_step  (cnt_step),
        .o_beat  (beat),
        .o_last  (beat_last)
    );

    cache_tag_array u_tags (
        .clk            (clk),
        .arst           (arst),
        .i_addr         (addr),
        .i_victim_way   (victim_way),
        .i_tag_write    (tag_write),
        .i_dirty_set    (dirty_set),
        .o_hit          (hit),
        .o_hit_way      (hit_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag)
    );

    lru_tracker u_lru (
        .clk          (clk),
        .arst         (arst),
        .i_set        (addr.set),
        .i_touch      (lru_touch),
        .i_way        (hit_way),
        .o_victim_way (victim_way)
    );

    // Refill beats or CPU store data.
    assign data_wdata = data_src_fill ? i_mem_rd_rsp.rdata : wdata;

    cache_data_array u_data (
        .clk     (clk),
        .i_set   (addr.set),
        .i_way   (use_victim ? victim_way : hit_way),
        .i_word  (use_victim ? beat : addr.word),
        .i_we    (data_we),
        .i_wdata (data_wdata),
        .o_rdata (data_rdata)
    );

    // --------------------
    // Port assembly.
    // --------------------
    assign o_cpu_rsp.done  = done;
    assign o_cpu_rsp.rdata = (op == OP_READ) ? data_rdata : '0;

    // Write-back goes to the victim's own line address.
    assign o_mem_wr_req.awvalid = wr_ctl.awvalid;
    assign o_mem_wr_req.awaddr  = {victim_tag, addr.set, {(`CACHE_WORD_W + 2){1'b0}}};
    assign o_mem_wr_req.wvalid  = wr_ctl.wvalid;
    assign o_mem_wr_req.wdata   = data_rdata;
    assign o_mem_wr_req.wlast   = wr_ctl.wlast;

endmodule

//--- source/lru_tracker.sv
// --------------------
// Per-set LRU ages and victim way choice.
// --------------------
`timescale 1ns/100ps
`include "cache_consts.svh"

module lru_tracker (
    input  logic                       clk,
    input  logic                       arst,
    input  cache_types_pkg::set_idx_t  i_set,
    input  logic                       i_touch,
    input  cache_types_pkg::way_idx_t  i_way,
    output cache_types_pkg::way_idx_t  o_victim_way
);
    import cache_types_pkg::*;

    // Age 0 is most recent, age 3 is the victim.
    logic [`CACHE_WAY_W-1:0] age_q [`CACHE_SETS][`CACHE_WAYS];

    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    age_q[s][w] <= way_idx_t'(w);
                end
            end
        end else if (i_touch) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (way_idx_t'(w) == i_way) begin
                    age_q[i_set][w] <= '0;
                end else if (age_q[i_set][w] < age_q[i_set][i_way]) begin
                    age_q[i_set][w] <= age_q[i_set][w] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        o_victim_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (age_q[i_set][w] == '1) begin
                o_victim_way = way_idx_t'(w);
            end
        end
    end

endmodule

//--- source/mem_bus_pkg.sv
// --------------------
// Memory bus channel structs.
// Read: address and data beats with last.
// Write: address, data beats with last, response.
// --------------------
`include "cache_consts.svh"

package mem_bus_pkg;

    // Read address out, read data in.
    typedef struct packed {
        logic                     arvalid;
        logic [`CACHE_ADDR_W-1:0] araddr;
    } mem_rd_req_t;

    typedef struct packed {
        logic                     arready;
        logic                     rvalid;
        logic [`CACHE_DATA_W-1:0] rdata;
        logic                     rlast;
    } mem_rd_rsp_t;

    // Write address and data out, handshakes in.
    typedef struct packed {
        logic                     awvalid;
        logic [`CACHE_ADDR_W-1:0] awaddr;
        logic                     wvalid;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic                     wlast;
    } mem_wr_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } mem_wr_rsp_t;

endpackage

//--- tb.f
+incdir+source
source/cache_types_pkg.sv
source/mem_bus_pkg.sv
source/burst_counter.sv
source/cache_tag_array.sv
source/lru_tracker.sv
source/cache_data_array.sv
source/data_cache_fsm.sv
source/data_cache_top.sv
verif/mem_model.sv
verif/tb_data_cache.sv

//--- verif/mem_model.sv
// --------------------
// Burst memory responder for the data cache testbench.
// Random 0-2 cycle ready and beat delays, sparse word store
// with an address-based reset pattern, burst counters and
// write beat checks.
// --------------------
`timescale 1ns/100ps

module mem_model (
    input  logic                     clk,
    input  logic                     arst,
    input  mem_bus_pkg::mem_rd_req_t i_rd_req,
    input  mem_bus_pkg::mem_wr_req_t i_wr_req,
    output mem_bus_pkg::mem_rd_rsp_t o_rd_rsp,
    output mem_bus_pkg::mem_wr_rsp_t o_wr_rsp,
    output logic [31:0]              o_rd_bursts,
    output logic [31:0]              o_wr_bursts,
    output logic [31:0]              o_last_wb_addr,
    output logic [31:0]              o_wbeat_errs
);

    logic [31:0] store [logic [31:0]];
    logic [31:0] rng;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Unwritten words read back as their address xor a fixed pattern.
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr ^ 32'h5a5a_0000;
    endfunction

    task automatic random_wait();
        int n;
        rng = xorshift(rng);
        n = int'(rng % 32'd3);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // --------------------
    // Read burst.
    // --------------------
    task automatic serve_read();
        logic [31:0] base;
        base = i_rd_req.araddr;
        random_wait();
        o_rd_rsp.arready = 1'b1;
        @(posedge clk);
        #1;
        o_rd_rsp.arready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            random_wait();
            o_rd_rsp.rvalid = 1'b1;
            o_rd_rsp.rdata  = read_word(base + 32'(4 * i));
            o_rd_rsp.rlast  = (i == 3);
            @(posedge clk);
            #1;
            o_rd_rsp.rvalid = 1'b0;
            o_rd_rsp.rlast  = 1'b0;
        end
        o_rd_bursts = o_rd_bursts + 32'd1;
    endtask

    // --------------------
    // Write burst.
    // --------------------
    task automatic serve_write();
        logic [31:0] base;
        base = i_wr_req.awaddr;
        random_wait();
        o_wr_rsp.awready = 1'b1;
        @(posedge clk);
        #1;
        o_wr_rsp.awready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            random_wait();
            o_wr_rsp.wready = 1'b1;
            store[base + 32'(4 * i)] = i_wr_req.wdata;
            // Each beat needs wvalid, and wlast only on the fourth.
            if (i_wr_req.wvalid !== 1'b1 || i_wr_req.wlast !== (i == 3)) begin
                o_wbeat_errs = o_wbeat_errs + 32'd1;
            end
            @(posedge clk);
            #1;
            o_wr_rsp.wready = 1'b0;
        end
        random_wait();
        o_wr_rsp.bvalid = 1'b1;
        @(posedge clk);
        #1;
        o_wr_rsp.bvalid = 1'b0;
        o_last_wb_addr = base;
        o_wr_bursts    = o_wr_bursts + 32'd1;
    endtask

    // Serves one burst at a time, shortly after each clock edge.
    initial begin
        rng            = 32'hab6f_625a;
        o_rd_rsp       = '0;
        o_wr_rsp       = '0;
        o_rd_bursts    = '0;
        o_wr_bursts    = '0;
        o_last_wb_addr = '0;
        o_wbeat_errs   = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!arst && i_wr_req.awvalid) begin
                serve_write();
            end else if (!arst && i_rd_req.arvalid) begin
                serve_read();
            end
        end
    end

endmodule

//--- verif/tb_data_cache.sv
// --------------------
// Data cache testbench.
// Clock and reset, stimulus table, shadow memory and LRU
// reference model, per-entry checks and a cycle limit.
// --------------------
`timescale 1ns/100ps

module tb_data_cache;
    import cache_types_pkg::*;
    import mem_bus_pkg::*;

    localparam int NUM_ENTRIES  = 21;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 8;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + IDLE_CYCLES + NUM_ENTRIES * 40;

    typedef struct packed {
        cpu_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        exp_hit;
    } entry_t;

    logic        clk;
    logic        arst;
    cpu_req_t    cpu_req;
    cpu_rsp_t    cpu_rsp;
    mem_rd_req_t rd_req;
    mem_rd_rsp_t rd_rsp;
    mem_wr_req_t wr_req;
    mem_wr_rsp_t wr_rsp;
    logic [31:0] rd_bursts;
    logic [31:0] wr_bursts;
    logic [31:0] last_wb_addr;
    logic [31:0] wbeat_errs;
    entry_t      stim [NUM_ENTRIES];
    int          cycles = 0;

    // Reference cache state and coherent memory view.
    logic [23:0] shadow_tag   [16][4];
    logic        shadow_valid [16][4];
    logic        shadow_dirty [16][4];
    logic [1:0]  shadow_age   [16][4];
    logic [31:0] shadow_mem   [logic [31:0]];

    data_cache_top dut (
        .clk          (clk),
        .arst         (arst),
        .i_cpu_req    (cpu_req),
        .i_mem_rd_rsp (rd_rsp),
        .i_mem_wr_rsp (wr_rsp),
        .o_cpu_rsp    (cpu_rsp),
        .o_mem_rd_req (rd_req),
        .o_mem_wr_req (wr_req)
    );

    mem_model u_mem (
        .clk            (clk),
        .arst           (arst),
        .i_rd_req       (rd_req),
        .i_wr_req       (wr_req),
        .o_rd_rsp       (rd_rsp),
        .o_wr_rsp       (wr_rsp),
        .o_rd_bursts    (rd_bursts),
        .o_wr_bursts    (wr_bursts),
        .o_last_wb_addr (last_wb_addr),
        .o_wbeat_errs   (wbeat_errs)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("ERRORS FOUND");
            $fatal(1, "Timeout: the run took more than %0d cycles.", CYCLE_LIMIT);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "Value mismatch on %s.", name);
        end
    endtask

    // --------------------
    // Stimulus table.
    // --------------------
    task automatic load_table();
        // Set 2 takes a cold miss, hits and a dirty word before four more lines evict it.
        stim[0]  = '{OP_READ,  32'h0000_1020, 32'h0000_0000, 1'b0};
        stim[1]  = '{OP_READ,  32'h0000_1028, 32'h0000_0000, 1'b1};
        stim[2]  = '{OP_WRITE, 32'h0000_1024, 32'hdead_beef, 1'b1};
        stim[3]  = '{OP_READ,  32'h0000_1024, 32'h0000_0000, 1'b1};
        stim[4]  = '{OP_READ,  32'h0000_2020, 32'h0000_0000, 1'b0};
        stim[5]  = '{OP_READ,  32'h0000_3020, 32'h0000_0000, 1'b0};
        stim[6]  = '{OP_READ,  32'h0000_4020, 32'h0000_0000, 1'b0};
        stim[7]  = '{OP_READ,  32'h0000_5020, 32'h0000_0000, 1'b0};
        stim[8]  = '{OP_READ,  32'h0000_1024, 32'h0000_0000, 1'b0};
        // Write miss in set 3 and a second dirty eviction there.
        stim[9]  = '{OP_WRITE, 32'h0000_1030, 32'h1234_5678, 1'b0};
        stim[10] = '{OP_READ,  32'h0000_1030, 32'h0000_0000, 1'b1};
        // Hit on the set 2 line that replaced the dirty one.
        stim[11] = '{OP_READ,  32'h0000_5028, 32'h0000_0000, 1'b1};
        stim[12] = '{OP_READ,  32'h0000_2030, 32'h0000_0000, 1'b0};
        stim[13] = '{OP_READ,  32'h0000_3030, 32'h0000_0000, 1'b0};
        stim[14] = '{OP_WRITE, 32'h0000_4034, 32'h0bad_f00d, 1'b0};
        stim[15] = '{OP_READ,  32'h0000_5030, 32'h0000_0000, 1'b0};
        stim[16] = '{OP_READ,  32'h0000_1030, 32'h0000_0000, 1'b0};
        stim[17] = '{OP_READ,  32'h0000_4034, 32'h0000_0000, 1'b1};
        // Set 12.
        stim[18] = '{OP_READ,  32'h0000_abc0, 32'h0000_0000, 1'b0};
        stim[19] = '{OP_WRITE, 32'h0000_abcc, 32'h5555_aaaa, 1'b1};
        stim[20] = '{OP_READ,  32'h0000_abcc, 32'h0000_0000, 1'b1};
    endtask

    // --------------------
    // Reference model.
    // --------------------
    task automatic reset_model();
        for (int s = 0; s < 16; s++) begin
            for (int w = 0; w < 4; w++) begin
                shadow_valid[s][w] = 1'b0;
                shadow_dirty[s][w] = 1'b0;
                shadow_age[s][w]   = 2'(w);
            end
        end
    endtask

    // Touched way becomes newest and the more recent ones age by one.
    task automatic touch_way(input logic [3:0] set, input int way);
        logic [1:0] old;
        old = shadow_age[set][way];
        for (int w = 0; w < 4; w++) begin
            if (w == way) begin
                shadow_age[set][w] = 2'd0;
            end else if (shadow_age[set][w] < old) begin
                shadow_age[set][w] = shadow_age[set][w] + 2'd1;
            end
        end
    endtask

    task automatic predict(input entry_t e, output logic hit, output logic wb,
                           output logic [31:0] wb_addr, output logic [31:0] rdata);
        logic [3:0]  set;
        logic [23:0] tag;
        logic [31:0] waddr;
        int          way;
        set     = e.addr[7:4];
        tag     = e.addr[31:8];
        waddr   = {e.addr[31:2], 2'b00};
        hit     = 1'b0;
        wb      = 1'b0;
        wb_addr = '0;
        rdata   = '0;
        way     = 0;
        for (int w = 0; w < 4; w++) begin
            if (shadow_valid[set][w] && shadow_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            for (int w = 0; w < 4; w++) begin
                if (shadow_age[set][w] == 2'd3) begin
                    way = w;
                end
            end
            wb      = shadow_valid[set][way] && shadow_dirty[set][way];
            wb_addr = {shadow_tag[set][way], set, 4'h0};
            shadow_tag[set][way]   = tag;
            shadow_valid[set][way] = 1'b1;
            shadow_dirty[set][way] = 1'b0;
        end
        touch_way(set, way);
        if (e.op == OP_WRITE) begin
            shadow_mem[waddr]      = e.wdata;
            shadow_dirty[set][way] = 1'b1;
        end else if (shadow_mem.exists(waddr)) begin
            rdata = shadow_mem[waddr];
        end else begin
            rdata = waddr ^ 32'h5a5a_0000;
        end
    endtask

    // Nothing may move while the CPU port is quiet.
    task automatic idle_check();
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("done", 32'h0, 32'(cpu_rsp.done));
            check_value("arvalid", 32'h0, 32'(rd_req.arvalid));
            check_value("awvalid", 32'h0, 32'(wr_req.awvalid));
        end
    endtask

    // --------------------
    // Main sequence.
    // --------------------
    initial begin
        logic [31:0] exp_rdata;
        logic [31:0] exp_wb_addr;
        logic [31:0] rd0;
        logic [31:0] wr0;
        logic        exp_hit;
        logic        exp_wb;
        int          lat;
        clk     = 1'b0;
        arst    = 1'b1;
        cpu_req = '0;
        load_table();
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst = 1'b0;
        idle_check();

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            predict(stim[i], exp_hit, exp_wb, exp_wb_addr, exp_rdata);
            rd0 = rd_bursts;
            wr0 = wr_bursts;
            @(posedge clk);
            #1;
            cpu_req.valid = 1'b1;
            cpu_req.op    = stim[i].op;
            cpu_req.addr  = stim[i].addr;
            cpu_req.wdata = stim[i].wdata;
            // First negedge falls before the accepting edge.
            lat = 0;
            do begin
                @(negedge clk);
                lat++;
            end while (!cpu_rsp.done);

            check_value("hit (done one cycle after accept)",
                        32'(stim[i].exp_hit), 32'(lat == 2));
            if (stim[i].op == OP_READ) begin
                check_value("rdata", exp_rdata, cpu_rsp.rdata);
            end
            check_value("read bursts", exp_hit ? 32'd0 : 32'd1, rd_bursts - rd0);
            check_value("write bursts", 32'(exp_wb), wr_bursts - wr0);
            if (exp_wb) begin
                check_value("awaddr", exp_wb_addr, last_wb_addr);
            end
            check_value("write beat errors", 32'h0, wbeat_errs);

            @(posedge clk);
            #1;
            cpu_req = '0;
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule
